// ==== design/fetch_pkg.sv ====
// fetch package with address and instruction widths, queue sizing, exception record and causes
package fetch_pkg;

    // --------------------
    // datapath widths
    // --------------------

    // address / pc width of the rv64 core
    localparam int unsigned XLEN = 64;
    // every fetched word is handled as one instruction
    localparam int unsigned ILEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [ILEN-1:0] instr_t;

    // --------------------
    // prefetch queue
    // --------------------

    // entries in the fetch queue, kept a power of two so pointers wrap by themselves
    localparam int unsigned PREFETCH_DEPTH = 2;
    localparam int unsigned PREFETCH_PTR_W = $clog2(PREFETCH_DEPTH);

    // read / write pointer into the queue
    typedef logic [PREFETCH_PTR_W-1:0] fifo_ptr_t;
    // fill level, one bit wider to hold a full queue
    typedef logic [PREFETCH_PTR_W:0] fifo_cnt_t;

    // --------------------
    // exceptions
    // --------------------

    // exception record handed to decode with every instruction
    typedef struct packed {
        logic [XLEN-1:0] cause;
        // faulting instruction, zero-extended
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception_t;

    // mcause code for an illegal instruction
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 64'd2;

endpackage

// ==== design/rvc_pkg.sv ====
// rvc package with opcode, funct3, funct7 and register encodings for compressed expansion
package rvc_pkg;

    // --------------------
    // major opcodes
    // --------------------
    localparam logic [6:0] OPCODE_LOAD      = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE     = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPCODE_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPCODE_LUI       = 7'b0110111;
    localparam logic [6:0] OPCODE_OP        = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_32     = 7'b0111011;
    localparam logic [6:0] OPCODE_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL       = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR      = 7'b1100111;

    // compressed quadrants, code 11 marks a full 32-bit word
    localparam logic [1:0] C_QUADRANT_0 = 2'b00;
    localparam logic [1:0] C_QUADRANT_1 = 2'b01;
    localparam logic [1:0] C_QUADRANT_2 = 2'b10;

    // --------------------
    // function fields
    // --------------------
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    // word and doubleword width for loads and stores
    localparam logic [2:0] F3_W   = 3'b010;
    localparam logic [2:0] F3_D   = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // upper six bits double as funct6 for the rv64 shifts
    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // registers implied by compressed forms
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

endpackage

// ==== design/fetch_intf.sv ====
// fetch interface carrying queued words from the prefetch buffer to the IF stage
`timescale 1ns/1ps

interface fetch_intf import fetch_pkg::*; ();

    // head of the prefetch queue
    logic   valid;
    logic   ready;
    instr_t rdata;
    addr_t  addr;

    // restart of the fetch stream, start is a single-cycle strobe
    logic   start;
    addr_t  start_addr;

    // prefetch buffer side
    modport producer (
        output valid, rdata, addr,
        input  ready, start, start_addr
    );

    // IF stage side
    modport consumer (
        input  valid, rdata, addr,
        output ready, start, start_addr
    );

endinterface

// ==== design/prefetch_buffer.sv ====
// prefetch buffer issuing sequential word fetches and queueing returned words with addresses
`timescale 1ns/1ps

module prefetch_buffer import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // queue head towards the IF stage
    fetch_intf.producer fetch,
    // instruction memory port
    output logic        instr_req_o,
    output addr_t       instr_addr_o,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  instr_t      instr_rdata_i,
    output logic        busy_o
);

    // fetch control
    logic      active_q;
    logic      outstanding_q;
    logic      discard_q;
    logic      granted;
    addr_t     fetch_addr_q;
    // address of the word that is in flight
    addr_t     rsp_addr_q;

    // queue storage
    instr_t    data_mem [PREFETCH_DEPTH];
    addr_t     addr_mem [PREFETCH_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;
    logic      push;
    logic      pop;

    // --------------------
    // memory request side
    // --------------------

    // single outstanding request, raised only with a free slot in the queue
    assign instr_req_o  = active_q & ~outstanding_q & (count_q < fifo_cnt_t'(PREFETCH_DEPTH));
    assign instr_addr_o = fetch_addr_q;
    assign granted      = instr_req_o & instr_gnt_i;
    assign busy_o       = outstanding_q | (count_q != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q      <= 1'b0;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
            fetch_addr_q  <= '0;
        end else begin
            outstanding_q <= granted | (outstanding_q & ~instr_rvalid_i);
            if (fetch.start) begin
                active_q     <= 1'b1;
                // word aligned restart
                fetch_addr_q <= {fetch.start_addr[XLEN-1:2], 2'b00};
                // a response still on its way belongs to the old stream
                discard_q    <= granted | (outstanding_q & ~instr_rvalid_i);
            end else begin
                if (granted) begin
                    fetch_addr_q <= fetch_addr_q + addr_t'(4);
                end
                if (instr_rvalid_i) begin
                    discard_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (granted) begin
            rsp_addr_q <= fetch_addr_q;
        end
    end

    // --------------------
    // fetch queue
    // --------------------

    // space is reserved at request time so a push never meets a full queue
    assign push = instr_rvalid_i & ~discard_q & ~fetch.start;
    assign pop  = fetch.valid & fetch.ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (fetch.start) begin
            // restart drops everything queued so far
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
            end
            if (push && !pop) begin
                count_q <= count_q + fifo_cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - fifo_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= instr_rdata_i;
            addr_mem[wr_ptr_q] <= rsp_addr_q;
        end
    end

    // head entry stays put until popped
    assign fetch.valid = (count_q != '0);
    assign fetch.rdata = data_mem[rd_ptr_q];
    assign fetch.addr  = addr_mem[rd_ptr_q];

    // memory only grants a request that is up
    gnt_with_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_gnt_i |-> instr_req_o)
        else $error("instruction grant without request");

    // a response needs an earlier grant
    rvalid_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_i |-> outstanding_q)
        else $error("instruction rvalid without outstanding request");

endmodule

// ==== design/compressed_decoder.sv ====
// compressed decoder expanding rv64c instructions to 32 bits and flagging illegal encodings
`timescale 1ns/1ps

module compressed_decoder import fetch_pkg::*, rvc_pkg::*; (
    input  instr_t instr_i,
    output instr_t instr_o,
    output logic   is_compressed_o,
    output logic   illegal_instr_o
);

    // register fields of the compressed formats
    logic [4:0] rd;
    logic [4:0] rs2;
    // popular registers x8..x15, rs2_p is also rd' in quadrant 0
    logic [4:0] rs1_p;
    logic [4:0] rs2_p;

    assign rd    = instr_i[11:7];
    assign rs2   = instr_i[6:2];
    assign rs1_p = {2'b01, instr_i[9:7]};
    assign rs2_p = {2'b01, instr_i[4:2]};

    assign is_compressed_o = (instr_i[1:0] != 2'b11);

    always_comb begin
        // full words and unused upper halves pass through
        instr_o         = instr_i;
        illegal_instr_o = 1'b0;

        unique case (instr_i[1:0])
            // --------------------
            // quadrant 0
            // --------------------
            C_QUADRANT_0: begin
                unique case (instr_i[15:13])
                    3'b000: begin
                        // c.addi4spn becomes addi rd', sp, nzuimm
                        instr_o = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6],
                                   2'b00, REG_SP, F3_ADD, rs2_p, OPCODE_OP_IMM};
                        // zero immediate is reserved and covers the all-zero word too
                        illegal_instr_o = (instr_i[12:5] == 8'h00);
                    end
                    3'b010: instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                                       rs1_p, F3_W, rs2_p, OPCODE_LOAD};
                    3'b011: instr_o = {4'b0, instr_i[6:5], instr_i[12:10], 3'b000,
                                       rs1_p, F3_D, rs2_p, OPCODE_LOAD};
                    3'b110: instr_o = {5'b0, instr_i[5], instr_i[12], rs2_p, rs1_p, F3_W,
                                       instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
                    3'b111: instr_o = {4'b0, instr_i[6:5], instr_i[12], rs2_p, rs1_p, F3_D,
                                       instr_i[11:10], 3'b000, OPCODE_STORE};
                    // float loads/stores and the reserved slot
                    default: illegal_instr_o = 1'b1;
                endcase
            end

            // --------------------
            // quadrant 1
            // --------------------
            C_QUADRANT_1: begin
                unique case (instr_i[15:13])
                    3'b000: instr_o = {{6{instr_i[12]}}, instr_i[12], rs2, rd, F3_ADD, rd,
                                       OPCODE_OP_IMM};
                    3'b001: begin
                        // c.addiw, rd of x0 is reserved
                        instr_o = {{6{instr_i[12]}}, instr_i[12], rs2, rd, F3_ADD, rd,
                                   OPCODE_OP_IMM_32};
                        illegal_instr_o = (rd == REG_ZERO);
                    end
                    3'b010: instr_o = {{6{instr_i[12]}}, instr_i[12], rs2, REG_ZERO, F3_ADD, rd,
                                       OPCODE_OP_IMM};
                    3'b011: begin
                        if (rd == REG_SP) begin
                            // c.addi16sp
                            instr_o = {{3{instr_i[12]}}, instr_i[4:3], instr_i[5], instr_i[2],
                                       instr_i[6], 4'b0000, REG_SP, F3_ADD, REG_SP,
                                       OPCODE_OP_IMM};
                        end else begin
                            instr_o = {{15{instr_i[12]}}, rs2, rd, OPCODE_LUI};
                        end
                        // zero immediate reserved for both
                        illegal_instr_o = ({instr_i[12], rs2} == 6'b0);
                    end
                    3'b100: begin
                        unique case (instr_i[11:10])
                            2'b00: instr_o = {F7_ZERO[6:1], instr_i[12], rs2, rs1_p, F3_SR,
                                              rs1_p, OPCODE_OP_IMM};
                            2'b01: instr_o = {F7_SUB[6:1], instr_i[12], rs2, rs1_p, F3_SR,
                                              rs1_p, OPCODE_OP_IMM};
                            2'b10: instr_o = {{6{instr_i[12]}}, instr_i[12], rs2, rs1_p, F3_AND,
                                              rs1_p, OPCODE_OP_IMM};
                            default: begin
                                // register-register arithmetic on x8..x15
                                unique case ({instr_i[12], instr_i[6:5]})
                                    3'b000: instr_o = {F7_SUB, rs2_p, rs1_p, F3_ADD, rs1_p,
                                                       OPCODE_OP};
                                    3'b001: instr_o = {F7_ZERO, rs2_p, rs1_p, F3_XOR, rs1_p,
                                                       OPCODE_OP};
                                    3'b010: instr_o = {F7_ZERO, rs2_p, rs1_p, F3_OR, rs1_p,
                                                       OPCODE_OP};
                                    3'b011: instr_o = {F7_ZERO, rs2_p, rs1_p, F3_AND, rs1_p,
                                                       OPCODE_OP};
                                    3'b100: instr_o = {F7_SUB, rs2_p, rs1_p, F3_ADD, rs1_p,
                                                       OPCODE_OP_32};
                                    3'b101: instr_o = {F7_ZERO, rs2_p, rs1_p, F3_ADD, rs1_p,
                                                       OPCODE_OP_32};
                                    default: illegal_instr_o = 1'b1;
                                endcase
                            end
                        endcase
                    end
                    // c.j scrambles its offset into the jal immediate layout
                    3'b101: instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                                       instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                                       instr_i[12], {8{instr_i[12]}}, REG_ZERO, OPCODE_JAL};
                    // c.beqz / c.bnez
                    default: instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], REG_ZERO,
                                        rs1_p, (instr_i[13] ? F3_BNE : F3_BEQ), instr_i[11:10],
                                        instr_i[4:3], instr_i[12], OPCODE_BRANCH};
                endcase
            end

            // --------------------
            // quadrant 2
            // --------------------
            C_QUADRANT_2: begin
                unique case (instr_i[15:13])
                    3'b000: instr_o = {F7_ZERO[6:1], instr_i[12], rs2, rd, F3_SLL, rd,
                                       OPCODE_OP_IMM};
                    3'b010: begin
                        instr_o = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00, REG_SP,
                                   F3_W, rd, OPCODE_LOAD};
                        illegal_instr_o = (rd == REG_ZERO);
                    end
                    3'b011: begin
                        instr_o = {3'b0, instr_i[4:2], instr_i[12], instr_i[6:5], 3'b000, REG_SP,
                                   F3_D, rd, OPCODE_LOAD};
                        illegal_instr_o = (rd == REG_ZERO);
                    end
                    3'b100: begin
                        if (rs2 != REG_ZERO) begin
                            // c.mv adds to x0, c.add adds to rd
                            instr_o = {F7_ZERO, rs2, (instr_i[12] ? rd : REG_ZERO), F3_ADD, rd,
                                       OPCODE_OP};
                        end else begin
                            // c.jr links nothing, c.jalr links ra
                            instr_o = {12'b0, rd, F3_ADD, (instr_i[12] ? REG_RA : REG_ZERO),
                                       OPCODE_JALR};
                            // rs1 of x0 is reserved, or c.ebreak which is not supported
                            illegal_instr_o = (rd == REG_ZERO);
                        end
                    end
                    3'b110: instr_o = {4'b0, instr_i[8:7], instr_i[12], rs2, REG_SP, F3_W,
                                       instr_i[11:9], 2'b00, OPCODE_STORE};
                    3'b111: instr_o = {3'b0, instr_i[9:7], instr_i[12], rs2, REG_SP, F3_D,
                                       instr_i[11:10], 3'b000, OPCODE_STORE};
                    default: illegal_instr_o = 1'b1;
                endcase
            end

            default: ;
        endcase
    end

endmodule

// ==== design/if_stage.sv ====
// IF stage with start-up FSM, compressed decoder, hand-off control and IF/ID register
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_i,
    input  logic        id_ready_i,
    input  logic        halt_if_i,
    input  addr_t       boot_addr_i,
    // queue head from the prefetch buffer
    fetch_intf.consumer fetch,
    // IF/ID pipeline register
    output logic        instr_valid_id_o,
    output instr_t      instr_rdata_id_o,
    output logic        is_compressed_id_o,
    output logic        illegal_c_insn_id_o,
    output addr_t       pc_if_o,
    output addr_t       pc_id_o,
    output exception_t  ex_o
);

    typedef enum logic {
        IDLE,
        RUN
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;

    // decoder results for the queue head
    instr_t instr_expanded;
    logic   instr_compressed;
    logic   instr_illegal;

    logic   transfer;
    logic   ex_valid_q;
    addr_t  ex_tval_q;

    // --------------------
    // start-up FSM
    // --------------------
    always_comb begin
        state_d     = state_q;
        fetch.start = 1'b0;
        unique case (state_q)
            IDLE: begin
                // first request kicks off fetching at the boot address
                if (req_i) begin
                    fetch.start = 1'b1;
                    state_d     = RUN;
                end
            end
            // without redirects the stream runs until reset
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign fetch.start_addr = boot_addr_i;

    // hand-off only while running and decode can take a new instruction
    assign fetch.ready = (state_q == RUN) & req_i & id_ready_i & ~halt_if_i;
    assign transfer    = fetch.valid & fetch.ready;
    assign pc_if_o     = fetch.addr;

    compressed_decoder compressed_decoder_i (
        .instr_i         (fetch.rdata),
        .instr_o         (instr_expanded),
        .is_compressed_o (instr_compressed),
        .illegal_instr_o (instr_illegal)
    );

    // --------------------
    // IF/ID register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_valid_id_o <= 1'b0;
            ex_valid_q       <= 1'b0;
        end else if (transfer) begin
            instr_valid_id_o <= 1'b1;
            ex_valid_q       <= instr_illegal;
        end else if (id_ready_i) begin
            // decode consumed the instruction and nothing new arrived
            instr_valid_id_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (transfer) begin
            instr_rdata_id_o    <= instr_expanded;
            is_compressed_id_o  <= instr_compressed;
            illegal_c_insn_id_o <= instr_illegal;
            pc_id_o             <= fetch.addr;
            // original fetched word goes out as tval
            ex_tval_q           <= instr_illegal ? {{(XLEN-ILEN){1'b0}}, fetch.rdata} : '0;
        end
    end

    // record reads all zero unless the instruction is illegal
    assign ex_o.valid = ex_valid_q;
    assign ex_o.cause = ex_valid_q ? CAUSE_ILLEGAL_INSTR : '0;
    assign ex_o.tval  = ex_tval_q;

    // nothing is queued or handed to decode before the fetch stream was started
    valid_after_start_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == IDLE) |-> (!fetch.valid && !instr_valid_id_o))
        else $error("queued word or ID valid present while fetch was idle");

endmodule

// ==== design/fetch_top.sv ====
// fetch top level connecting prefetch buffer and IF stage behind plain ports
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   req_i,
    input  logic   id_ready_i,
    input  logic   halt_if_i,
    input  addr_t  boot_addr_i,
    // instruction memory port
    output logic   instr_req_o,
    output addr_t  instr_addr_o,
    input  logic   instr_gnt_i,
    input  logic   instr_rvalid_i,
    input  instr_t instr_rdata_i,
    output logic   if_busy_o,
    // towards decode
    output logic   instr_valid_id_o,
    output instr_t instr_rdata_id_o,
    output logic   is_compressed_id_o,
    output logic   illegal_c_insn_id_o,
    output addr_t  pc_if_o,
    output addr_t  pc_id_o,
    output logic   ex_valid_o,
    output addr_t  ex_cause_o,
    output addr_t  ex_tval_o
);

    // queue to stage link
    fetch_intf  fetch_if ();
    exception_t ex;

    prefetch_buffer prefetch_buffer_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fetch          (fetch_if.producer),
        .instr_req_o    (instr_req_o),
        .instr_addr_o   (instr_addr_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_rdata_i  (instr_rdata_i),
        .busy_o         (if_busy_o)
    );

    if_stage if_stage_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .req_i               (req_i),
        .id_ready_i          (id_ready_i),
        .halt_if_i           (halt_if_i),
        .boot_addr_i         (boot_addr_i),
        .fetch               (fetch_if.consumer),
        .instr_valid_id_o    (instr_valid_id_o),
        .instr_rdata_id_o    (instr_rdata_id_o),
        .is_compressed_id_o  (is_compressed_id_o),
        .illegal_c_insn_id_o (illegal_c_insn_id_o),
        .pc_if_o             (pc_if_o),
        .pc_id_o             (pc_id_o),
        .ex_o                (ex)
    );

    // exception record flattened for the port list
    assign ex_valid_o = ex.valid;
    assign ex_cause_o = ex.cause;
    assign ex_tval_o  = ex.tval;

endmodule

// ==== sim/tb_fetch_top.sv ====
// testbench for the fetch front end with memory model, stall stimulus, scoreboard and report
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int          NUM_VECTORS    = 18;
    // entries from this index on are taken under random stalls
    localparam int          STALL_FROM     = 6;
    localparam int          TIMEOUT_CYCLES = 40 * NUM_VECTORS + 100;
    localparam logic [63:0] BOOT_ADDR      = 64'h0000_0001_0000_1000;

    logic        clk_i;
    logic        rst_ni;
    logic        req_i;
    logic        id_ready_i;
    logic        halt_if_i;
    logic [63:0] boot_addr_i;
    logic        instr_req_o;
    logic [63:0] instr_addr_o;
    logic        instr_gnt_i;
    logic        instr_rvalid_i;
    logic [31:0] instr_rdata_i;
    logic        if_busy_o;
    logic        instr_valid_id_o;
    logic [31:0] instr_rdata_id_o;
    logic        is_compressed_id_o;
    logic        illegal_c_insn_id_o;
    logic [63:0] pc_if_o;
    logic [63:0] pc_id_o;
    logic        ex_valid_o;
    logic [63:0] ex_cause_o;
    logic [63:0] ex_tval_o;

    // four columns per entry with word, expected ID word, compressed and illegal flags
    logic [31:0] vectors [0:4*NUM_VECTORS-1];

    integer      seed = 9;
    int          cycle_cnt = 0;
    int          rcv_count = 0;
    bit          first_req_seen = 1'b0;
    int          checks [1:6];
    int          errors [1:6];
    string       test_names [1:6];

    // memory model state
    int          gnt_wait;
    bit          resp_due;
    logic [63:0] resp_addr;

    // request tracking and queue head as seen by the scoreboard
    bit          req_pending = 1'b0;
    logic [63:0] pending_addr;
    logic [63:0] head_pc;
    logic [63:0] last_pc_id;
    int          xfer_count = 0;

    fetch_top fetch_top_i (.*);

    // --------------------
    // clock and watchdog
    // --------------------
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout after %0d cycles with %0d of %0d instructions delivered",
                 cycle_cnt, rcv_count, NUM_VECTORS);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        logic [63:0] offset;
        offset = addr - BOOT_ADDR;
        if (addr >= BOOT_ADDR && offset < 64'(4 * NUM_VECTORS)) begin
            return vectors[4 * int'(offset[31:2])];
        end
        // filler past the program folds in every address bit
        return addr[63:32] ^ addr[31:0] ^ 32'h6b3c_91d7;
    endfunction

    task automatic check_value(input int test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        checks[test]++;
        assert (act === exp) else begin
            $display("ERROR %s, %s: expected %h, actual %h", test_names[test], what, exp, act);
            errors[test]++;
        end
    endtask

    task automatic check_true(input int test, input string what, input logic cond);
        checks[test]++;
        assert (cond === 1'b1) else begin
            $display("%s: %s", test_names[test], what);
            errors[test]++;
        end
    endtask

    task automatic compare_entry(input int idx);
        logic [31:0] word;
        logic [31:0] exp_id;
        logic        exp_c;
        logic        exp_ill;
        int          kind;
        string       tag;
        word    = vectors[4*idx];
        exp_id  = vectors[4*idx+1];
        exp_c   = vectors[4*idx+2][0];
        exp_ill = vectors[4*idx+3][0];
        tag     = $sformatf("entry %0d", idx);
        kind    = exp_ill ? 5 : (exp_c ? 4 : 3);
        // order shows in the pc
        // stalled entries count towards the stall test
        check_value((idx >= STALL_FROM) ? 6 : 2, {tag, " pc"}, BOOT_ADDR + 64'(4 * idx), pc_id_o);
        check_value(kind, {tag, " compressed flag"}, 64'(exp_c), 64'(is_compressed_id_o));
        if (exp_ill) begin
            check_value(5, {tag, " illegal flag"}, 64'd1, 64'(illegal_c_insn_id_o));
            check_value(5, {tag, " exception valid"}, 64'd1, 64'(ex_valid_o));
            check_value(5, {tag, " exception cause"}, 64'd2, ex_cause_o);
            check_value(5, {tag, " exception tval"}, {32'h0, word}, ex_tval_o);
        end else begin
            check_value(kind, {tag, " instruction"}, 64'(exp_id), 64'(instr_rdata_id_o));
            check_value(5, {tag, " illegal flag"}, 64'd0, 64'(illegal_c_insn_id_o));
            check_value(5, {tag, " exception valid"}, 64'd0, 64'(ex_valid_o));
        end
    endtask

    // grant after 0 to 2 cycles and rvalid one cycle after the grant
    task automatic answer_memory();
        instr_rvalid_i = resp_due;
        instr_rdata_i  = resp_due ? mem_word(resp_addr) : 32'h0;
        resp_due       = 1'b0;
        instr_gnt_i    = 1'b0;
        if (rst_ni && instr_req_o) begin
            if (gnt_wait == 0) begin
                instr_gnt_i = 1'b1;
                resp_due    = 1'b1;
                resp_addr   = instr_addr_o;
                gnt_wait    = $unsigned($random(seed)) % 3;
            end else begin
                gnt_wait--;
            end
        end
    endtask

    task automatic toggle_stalls();
        logic [31:0] rnd;
        rnd        = $random(seed);
        // decode is mostly ready and halts now and then
        id_ready_i = rnd[0] | rnd[1];
        halt_if_i  = rnd[2] & rnd[3];
    endtask

    task automatic report_test(input int test);
        $display("%-24s %s (%0d checks, %0d errors)", test_names[test],
                 (errors[test] == 0) ? "ok" : "FAILED", checks[test], errors[test]);
    endtask

    // --------------------
    // drivers and scoreboard
    // --------------------
    initial begin
        forever begin
            @(posedge clk_i);
            #1;
            answer_memory();
            if (rcv_count >= STALL_FROM && rcv_count < NUM_VECTORS) begin
                toggle_stalls();
            end
        end
    end

    // sampled half a cycle before the edge that consumes the ID entry
    always @(negedge clk_i) begin
        if (rst_ni) begin
            // a request stays up with the same address until granted
            if (req_pending) begin
                check_true(6, "request dropped or moved before its grant",
                           instr_req_o && instr_addr_o === pending_addr);
            end
            // only one request in flight
            if (instr_rvalid_i) begin
                check_true(6, "new request raised while a response was outstanding",
                           !instr_req_o);
            end
            req_pending  = instr_req_o && !instr_gnt_i;
            pending_addr = instr_addr_o;
            if (instr_req_o && !first_req_seen) begin
                first_req_seen = 1'b1;
                check_value(2, "first request address", BOOT_ADDR, instr_addr_o);
            end
            // a fresh ID entry came from the queue head seen one cycle earlier
            if (instr_valid_id_o && pc_id_o !== last_pc_id) begin
                check_value(2, "pc at queue head", BOOT_ADDR + 64'(4 * xfer_count), head_pc);
                last_pc_id = pc_id_o;
                xfer_count++;
            end
            head_pc = pc_if_o;
            if (instr_valid_id_o && id_ready_i && rcv_count < NUM_VECTORS) begin
                compare_entry(rcv_count);
                rcv_count++;
            end
        end
    end

    initial begin : stimulus
        int total_checks;
        int total_errors;
        test_names[1] = "idle after reset";
        test_names[2] = "boot address and pc";
        test_names[3] = "full words";
        test_names[4] = "compressed expansion";
        test_names[5] = "illegal exceptions";
        test_names[6] = "stalls and ordering";
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        rst_ni         = 1'b0;
        req_i          = 1'b0;
        id_ready_i     = 1'b1;
        halt_if_i      = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        resp_due       = 1'b0;
        resp_addr      = '0;
        gnt_wait       = $unsigned($random(seed)) % 3;
        $readmemh("sim/fetch_vectors.txt", vectors);

        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // nothing moves while req_i stays low
        repeat (5) begin
            @(negedge clk_i);
            check_true(1, "memory request raised while idle", !instr_req_o);
            check_true(1, "ID valid raised while idle", !instr_valid_id_o);
            check_true(1, "fetch busy while idle", !if_busy_o);
        end
        report_test(1);

        @(posedge clk_i);
        #1;
        req_i = 1'b1;
        while (rcv_count < NUM_VECTORS) begin
            @(posedge clk_i);
        end
        #1;
        req_i      = 1'b0;
        id_ready_i = 1'b1;
        halt_if_i  = 1'b0;

        total_checks = 0;
        total_errors = 0;
        for (int t = 2; t <= 6; t++) begin
            report_test(t);
        end
        for (int t = 1; t <= 6; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim/fetch_vectors.txt ====
// memory word, expected ID word, compressed flag, illegal flag (hex)
// entry n sits at the boot address plus 4*n, ID word unused for illegal entries
00a00093 00a00093 0 0
00004515 00500513 1 0
0000147d fff40413 1 0
002081b3 002081b3 0 0
000085aa 00a005b3 1 0
000095aa 00a585b3 1 0
00000000 00000000 1 1
00004144 00452483 1 0
0000e504 00953423 1 0
0000060e 00361613 1 0
00000004 00000000 1 1
00008c05 40940433 1 0
0000b103 0000b103 0 0
00002505 0015051b 1 0
12348000 00000000 1 1
00006285 000012b7 1 0
000060a2 00813083 1 0
00008002 00000000 1 1

// ==== sources.f ====
design/fetch_pkg.sv
design/rvc_pkg.sv
design/fetch_intf.sv
design/prefetch_buffer.sv
design/compressed_decoder.sv
design/if_stage.sv
design/fetch_top.sv
sim/tb_fetch_top.sv
